// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f build.f --top-module tb_soc_bus -o tb_soc_bus
	./obj_dir/tb_soc_bus | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+design
design/axi_pkg.sv
design/soc_pkg.sv
design/axi_crossbar.sv
design/axi_sram.sv
design/axi_uart.sv
design/soc_bus_top.sv
tests/tb_soc_bus.sv

// ==== design/axi_crossbar.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module axi_crossbar (
    input  logic         clk,
    input  logic         reset,

    input  axi_pkg::aw_t s_aw,
    input  logic         s_awvalid,
    output logic         s_awready,
    input  axi_pkg::w_t  s_w,
    input  logic         s_wvalid,
    output logic         s_wready,
    output axi_pkg::b_t  s_b,
    output logic         s_bvalid,
    input  logic         s_bready,
    input  axi_pkg::ar_t s_ar,
    input  logic         s_arvalid,
    output logic         s_arready,
    output axi_pkg::r_t  s_r,
    output logic         s_rvalid,
    input  logic         s_rready,

    output axi_pkg::aw_t sram_aw,
    output logic         sram_awvalid,
    input  logic         sram_awready,
    output axi_pkg::w_t  sram_w,
    output logic         sram_wvalid,
    input  logic         sram_wready,
    input  axi_pkg::b_t  sram_b,
    input  logic         sram_bvalid,
    output logic         sram_bready,
    output axi_pkg::ar_t sram_ar,
    output logic         sram_arvalid,
    input  logic         sram_arready,
    input  axi_pkg::r_t  sram_r,
    input  logic         sram_rvalid,
    output logic         sram_rready,

    output axi_pkg::aw_t uart_aw,
    output logic         uart_awvalid,
    input  logic         uart_awready,
    output axi_pkg::w_t  uart_w,
    output logic         uart_wvalid,
    input  logic         uart_wready,
    input  axi_pkg::b_t  uart_b,
    input  logic         uart_bvalid,
    output logic         uart_bready,
    output axi_pkg::ar_t uart_ar,
    output logic         uart_arvalid,
    input  logic         uart_arready,
    input  axi_pkg::r_t  uart_r,
    input  logic         uart_rvalid,
    output logic         uart_rready
);

    function automatic soc_pkg::target_e decode(input axi_pkg::addr_t addr);
        if (addr >= `SRAM_BASE && addr <= `SRAM_LAST)
            return soc_pkg::TGT_SRAM;
        if (addr == `UART_BASE)
            return soc_pkg::TGT_UART;
        return soc_pkg::TGT_NONE;
    endfunction

    soc_pkg::xbar_state_e wr_state, rd_state;
    soc_pkg::target_e     aw_tgt, ar_tgt, wr_owner, rd_owner;
    logic                 wr_idle, rd_idle;
    logic                 aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic                 dec_bvalid, dec_rvalid;
    axi_pkg::id_t         dec_bid, dec_rid;
    axi_pkg::len_t        dec_rlen, dec_rcnt;

    assign aw_tgt  = decode(s_aw.addr);
    assign ar_tgt  = decode(s_ar.addr);
    assign wr_idle = wr_state == soc_pkg::XBAR_IDLE;
    assign rd_idle = rd_state == soc_pkg::XBAR_IDLE;

    assign aw_hs = s_awvalid && s_awready;
    assign w_hs  = s_wvalid && s_wready;
    assign b_hs  = s_bvalid && s_bready;
    assign ar_hs = s_arvalid && s_arready;
    assign r_hs  = s_rvalid && s_rready;

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    assign sram_aw      = s_aw;
    assign uart_aw      = s_aw;
    assign sram_awvalid = s_awvalid && wr_idle && aw_tgt == soc_pkg::TGT_SRAM;
    assign uart_awvalid = s_awvalid && wr_idle && aw_tgt == soc_pkg::TGT_UART;

    always_comb begin
        case (aw_tgt)
            soc_pkg::TGT_SRAM: s_awready = wr_idle && sram_awready;
            soc_pkg::TGT_UART: s_awready = wr_idle && uart_awready;
            default:           s_awready = wr_idle;   // Unmapped address taken at once
        endcase
    end

    // W and B follow the registered owner
    assign sram_w      = s_w;
    assign uart_w      = s_w;
    assign sram_wvalid = s_wvalid && !wr_idle && wr_owner == soc_pkg::TGT_SRAM;
    assign uart_wvalid = s_wvalid && !wr_idle && wr_owner == soc_pkg::TGT_UART;
    assign sram_bready = s_bready && wr_owner == soc_pkg::TGT_SRAM;
    assign uart_bready = s_bready && wr_owner == soc_pkg::TGT_UART;

    always_comb begin
        case (wr_owner)
            soc_pkg::TGT_SRAM: begin
                s_wready = !wr_idle && sram_wready;
                s_bvalid = sram_bvalid;
                s_b      = sram_b;
            end
            soc_pkg::TGT_UART: begin
                s_wready = !wr_idle && uart_wready;
                s_bvalid = uart_bvalid;
                s_b      = uart_b;
            end
            default: begin
                s_wready = !wr_idle && !dec_bvalid;   // Sink beats until last
                s_bvalid = dec_bvalid;
                s_b.id   = dec_bid;
                s_b.resp = axi_pkg::RESP_DECERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state   <= soc_pkg::XBAR_IDLE;
            wr_owner   <= soc_pkg::TGT_NONE;
            dec_bvalid <= 1'b0;
        end else if (wr_idle) begin
            if (aw_hs) begin
                wr_state <= soc_pkg::XBAR_BUSY;
                wr_owner <= aw_tgt;
            end
        end else begin
            if (wr_owner == soc_pkg::TGT_NONE && w_hs && s_w.last)
                dec_bvalid <= 1'b1;
            if (b_hs) begin
                wr_state   <= soc_pkg::XBAR_IDLE;
                dec_bvalid <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    assign sram_ar      = s_ar;
    assign uart_ar      = s_ar;
    assign sram_arvalid = s_arvalid && rd_idle && ar_tgt == soc_pkg::TGT_SRAM;
    assign uart_arvalid = s_arvalid && rd_idle && ar_tgt == soc_pkg::TGT_UART;
    assign sram_rready  = s_rready && rd_owner == soc_pkg::TGT_SRAM;
    assign uart_rready  = s_rready && rd_owner == soc_pkg::TGT_UART;

    always_comb begin
        case (ar_tgt)
            soc_pkg::TGT_SRAM: s_arready = rd_idle && sram_arready;
            soc_pkg::TGT_UART: s_arready = rd_idle && uart_arready;
            default:           s_arready = rd_idle;
        endcase
    end

    always_comb begin
        case (rd_owner)
            soc_pkg::TGT_SRAM: begin
                s_rvalid = sram_rvalid;
                s_r      = sram_r;
            end
            soc_pkg::TGT_UART: begin
                s_rvalid = uart_rvalid;
                s_r      = uart_r;
            end
            default: begin
                s_rvalid = dec_rvalid;
                s_r.id   = dec_rid;
                s_r.data = '0;
                s_r.resp = axi_pkg::RESP_DECERR;
                s_r.last = dec_rcnt == dec_rlen;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state   <= soc_pkg::XBAR_IDLE;
            rd_owner   <= soc_pkg::TGT_NONE;
            dec_rvalid <= 1'b0;
        end else if (rd_idle) begin
            if (ar_hs) begin
                rd_state   <= soc_pkg::XBAR_BUSY;
                rd_owner   <= ar_tgt;
                dec_rvalid <= ar_tgt == soc_pkg::TGT_NONE;
            end
        end else if (r_hs && s_r.last) begin
            rd_state   <= soc_pkg::XBAR_IDLE;
            dec_rvalid <= 1'b0;
        end
    end

    // Unmapped responder payload
    always_ff @(posedge clk) begin
        if (aw_hs)
            dec_bid <= s_aw.id;
        if (ar_hs) begin
            dec_rid  <= s_ar.id;
            dec_rlen <= s_ar.len;
            dec_rcnt <= '0;
        end else if (r_hs) begin
            dec_rcnt <= dec_rcnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_b_idle: assert property (@(posedge clk) disable iff (reset) wr_idle |-> !s_bvalid);
    a_r_idle: assert property (@(posedge clk) disable iff (reset) rd_idle |-> !s_rvalid);

    // Never two subordinates answering at once
    a_one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sram_bvalid, uart_bvalid}) && $onehot0({sram_rvalid, uart_rvalid}));

endmodule

`default_nettype wire

// ==== design/axi_pkg.sv ====
`default_nettype none

`include "soc_defines.svh"

package axi_pkg;

    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [`ID_W-1:0]     id_t;
    typedef logic [7:0]           len_t;
    typedef logic [`DATA_W/8-1:0] strb_t;
    typedef logic [2:0]           size_t;
    typedef logic [1:0]           burst_t;
    typedef logic [1:0]           resp_t;

    localparam burst_t BURST_INCR = 2'b01;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    typedef struct packed {
        addr_t  addr;
        id_t    id;
        len_t   len;     // Beats minus one
        size_t  size;
        burst_t burst;
    } aw_t;

    typedef struct packed {
        addr_t  addr;
        id_t    id;
        len_t   len;
        size_t  size;
        burst_t burst;
    } ar_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_t;

endpackage

`default_nettype wire

// ==== design/axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module axi_sram (
    input  logic         clk,
    input  logic         reset,
    input  axi_pkg::aw_t aw,
    input  logic         awvalid,
    output logic         awready,
    input  axi_pkg::w_t  w,
    input  logic         wvalid,
    output logic         wready,
    output axi_pkg::b_t  b,
    output logic         bvalid,
    input  logic         bready,
    input  axi_pkg::ar_t ar,
    input  logic         arvalid,
    output logic         arready,
    output axi_pkg::r_t  r,
    output logic         rvalid,
    input  logic         rready
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    typedef logic [IDX_W-1:0] idx_t;

    soc_pkg::sram_state_e state;
    axi_pkg::data_t       mem [`SRAM_WORDS];
    idx_t                 idx;          // Current word of the burst
    axi_pkg::id_t         req_id;
    axi_pkg::len_t        len, cnt;
    logic                 aw_hs, w_hs, ar_hs, r_hs;

    assign awready = state == soc_pkg::SRAM_IDLE;
    assign arready = state == soc_pkg::SRAM_IDLE && !awvalid;   // Write wins a tie
    assign wready  = state == soc_pkg::SRAM_WDATA;
    assign bvalid  = state == soc_pkg::SRAM_WRESP;
    assign rvalid  = state == soc_pkg::SRAM_RDATA;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign b = '{id: req_id, resp: axi_pkg::RESP_OKAY};
    assign r = '{id: req_id, data: mem[idx], resp: axi_pkg::RESP_OKAY, last: cnt == len};

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= soc_pkg::SRAM_IDLE;
        end else begin
            case (state)
                soc_pkg::SRAM_IDLE: begin
                    if (aw_hs)
                        state <= soc_pkg::SRAM_WDATA;
                    else if (ar_hs)
                        state <= soc_pkg::SRAM_RDATA;
                end
                soc_pkg::SRAM_WDATA: begin
                    if (w_hs && w.last)
                        state <= soc_pkg::SRAM_WRESP;
                end
                soc_pkg::SRAM_WRESP: begin
                    if (bready)
                        state <= soc_pkg::SRAM_IDLE;
                end
                default: begin
                    if (r_hs && r.last)
                        state <= soc_pkg::SRAM_IDLE;
                end
            endcase
        end
    end

    // Burst address and beat count
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            idx    <= aw.addr[IDX_W+1:2];
            req_id <= aw.id;
        end else if (ar_hs) begin
            idx    <= ar.addr[IDX_W+1:2];
            req_id <= ar.id;
            len    <= ar.len;
            cnt    <= '0;
        end else if (w_hs) begin
            idx <= idx + 1'b1;
        end else if (r_hs) begin
            idx <= idx + 1'b1;
            cnt <= cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int i = 0; i < `DATA_W / 8; i++) begin
                if (w.strb[i])
                    mem[idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    a_incr: assert property (@(posedge clk) disable iff (reset)
        (aw_hs || ar_hs) |-> (aw_hs ? aw.burst : ar.burst) == axi_pkg::BURST_INCR);

endmodule

`default_nettype wire

// ==== design/axi_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_uart (
    input  logic         clk,
    input  logic         reset,
    input  axi_pkg::aw_t aw,
    input  logic         awvalid,
    output logic         awready,
    input  axi_pkg::w_t  w,
    input  logic         wvalid,
    output logic         wready,
    output axi_pkg::b_t  b,
    output logic         bvalid,
    input  logic         bready,
    input  axi_pkg::ar_t ar,
    input  logic         arvalid,
    output logic         arready,
    output axi_pkg::r_t  r,
    output logic         rvalid,
    input  logic         rready,
    output logic [7:0]   tx_byte,
    output logic         tx_valid
);

    soc_pkg::uart_state_e state;
    axi_pkg::id_t         req_id;
    logic [7:0]           sent_cnt;     // Bytes sent since reset
    logic                 aw_hs, w_hs, ar_hs, tx_hit;

    assign awready = state == soc_pkg::UART_IDLE;
    assign arready = state == soc_pkg::UART_IDLE && !awvalid;
    assign wready  = state == soc_pkg::UART_WDATA;
    assign bvalid  = state == soc_pkg::UART_WRESP;
    assign rvalid  = state == soc_pkg::UART_RRESP;

    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign ar_hs  = arvalid && arready;
    assign tx_hit = w_hs && w.strb[0];   // Only lane 0 carries the byte

    assign b = '{id: req_id, resp: axi_pkg::RESP_OKAY};
    assign r = '{id: req_id, data: axi_pkg::data_t'(sent_cnt),
                 resp: axi_pkg::RESP_OKAY, last: 1'b1};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= soc_pkg::UART_IDLE;
            tx_valid <= 1'b0;
            sent_cnt <= '0;
        end else begin
            tx_valid <= tx_hit;
            if (tx_hit)
                sent_cnt <= sent_cnt + 1'b1;
            case (state)
                soc_pkg::UART_IDLE: begin
                    if (aw_hs)
                        state <= soc_pkg::UART_WDATA;
                    else if (ar_hs)
                        state <= soc_pkg::UART_RRESP;
                end
                soc_pkg::UART_WDATA: if (w_hs) state <= soc_pkg::UART_WRESP;
                soc_pkg::UART_WRESP: if (bready) state <= soc_pkg::UART_IDLE;
                default:             if (rready) state <= soc_pkg::UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs)
            req_id <= aw.id;
        else if (ar_hs)
            req_id <= ar.id;
        if (w_hs)
            tx_byte <= w.data[7:0];
    end

    // Single-beat register
    a_single: assert property (@(posedge clk) disable iff (reset)
        (aw_hs || ar_hs) |-> (aw_hs ? aw.len : ar.len) == '0);

endmodule

`default_nettype wire

// ==== design/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  logic         clk,
    input  logic         reset,
    input  axi_pkg::aw_t s_aw,
    input  logic         s_awvalid,
    output logic         s_awready,
    input  axi_pkg::w_t  s_w,
    input  logic         s_wvalid,
    output logic         s_wready,
    output axi_pkg::b_t  s_b,
    output logic         s_bvalid,
    input  logic         s_bready,
    input  axi_pkg::ar_t s_ar,
    input  logic         s_arvalid,
    output logic         s_arready,
    output axi_pkg::r_t  s_r,
    output logic         s_rvalid,
    input  logic         s_rready,
    output logic [7:0]   tx_byte,
    output logic         tx_valid
);

    // --------------------------------------------------
    // Crossbar to subordinates
    // --------------------------------------------------
    axi_pkg::aw_t sram_aw, uart_aw;
    axi_pkg::w_t  sram_w, uart_w;
    axi_pkg::b_t  sram_b, uart_b;
    axi_pkg::ar_t sram_ar, uart_ar;
    axi_pkg::r_t  sram_r, uart_r;
    logic sram_awvalid, sram_awready, sram_wvalid, sram_wready, sram_bvalid, sram_bready;
    logic sram_arvalid, sram_arready, sram_rvalid, sram_rready;
    logic uart_awvalid, uart_awready, uart_wvalid, uart_wready, uart_bvalid, uart_bready;
    logic uart_arvalid, uart_arready, uart_rvalid, uart_rready;

    axi_crossbar axi_crossbar_i (.*);

    axi_sram axi_sram_i (
        .clk     (clk),
        .reset   (reset),
        .aw (sram_aw), .awvalid (sram_awvalid), .awready (sram_awready),
        .w  (sram_w),  .wvalid  (sram_wvalid),  .wready  (sram_wready),
        .b  (sram_b),  .bvalid  (sram_bvalid),  .bready  (sram_bready),
        .ar (sram_ar), .arvalid (sram_arvalid), .arready (sram_arready),
        .r  (sram_r),  .rvalid  (sram_rvalid),  .rready  (sram_rready)
    );

    axi_uart axi_uart_i (
        .clk     (clk),
        .reset   (reset),
        .aw (uart_aw), .awvalid (uart_awvalid), .awready (uart_awready),
        .w  (uart_w),  .wvalid  (uart_wvalid),  .wready  (uart_wready),
        .b  (uart_b),  .bvalid  (uart_bvalid),  .bready  (uart_bready),
        .ar (uart_ar), .arvalid (uart_arvalid), .arready (uart_arready),
        .r  (uart_r),  .rvalid  (uart_rvalid),  .rready  (uart_rready),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid)
    );

endmodule

`default_nettype wire

// ==== design/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// --------------------------------------------------
// Address map
// --------------------------------------------------
`define SRAM_BASE  32'h8000_0000
`define SRAM_LAST  32'h8FFF_FFFF
`define UART_BASE  32'h1000_0000

// Depth in 32-bit words
`define SRAM_WORDS 1024

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define ADDR_W 32
`define DATA_W 32
`define ID_W   4

`endif

// ==== design/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Owner of a transaction in the crossbar
    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_UART,
        TGT_NONE
    } target_e;

    typedef enum logic {
        XBAR_IDLE,
        XBAR_BUSY
    } xbar_state_e;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_WDATA,
        SRAM_WRESP,
        SRAM_RDATA
    } sram_state_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_WDATA,
        UART_WRESP,
        UART_RRESP
    } uart_state_e;

endpackage

`default_nettype wire

// ==== tests/tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc_bus;

    localparam int TIMEOUT = 200;   // Cycles allowed per wait

    logic         clk;
    logic         reset;
    axi_pkg::aw_t s_aw;
    logic         s_awvalid, s_awready;
    axi_pkg::w_t  s_w;
    logic         s_wvalid, s_wready;
    axi_pkg::b_t  s_b;
    logic         s_bvalid, s_bready;
    axi_pkg::ar_t s_ar;
    logic         s_arvalid, s_arready;
    axi_pkg::r_t  s_r;
    logic         s_rvalid, s_rready;
    logic [7:0]   tx_byte;
    logic         tx_valid;

    axi_pkg::data_t sb_mem [`SRAM_WORDS];   // Expected SRAM contents
    logic [7:0]     exp_bytes [$];          // Bytes still due on tx
    int             tx_count;
    axi_pkg::data_t wdata_q [$];
    axi_pkg::strb_t wstrb_q [$];
    logic           stall_en;
    string          test_name;
    int             checks, errors, tests, test_start;

    soc_bus_top soc_bus_top_i (.*);

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Checks and bookkeeping
    // --------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond) else begin
            $display("Failure in %s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("Test %-14s %s", test_name, errors == test_start ? "passed" : "failed");
    endtask

    function automatic axi_pkg::resp_t exp_resp(input soc_pkg::target_e tgt);
        return tgt == soc_pkg::TGT_NONE ? axi_pkg::RESP_DECERR : axi_pkg::RESP_OKAY;
    endfunction

    // Word index wraps at the SRAM depth
    function automatic int word_of(input axi_pkg::addr_t addr, input int beat);
        return int'(((addr >> 2) + beat) % `SRAM_WORDS);
    endfunction

    function automatic logic pick_ready();
        return stall_en ? $urandom_range(0, 1) == 1 : 1'b1;
    endfunction

    task automatic fill_beats(input axi_pkg::len_t len, input logic full);
        wdata_q.delete();
        wstrb_q.delete();
        for (int i = 0; i <= int'(len); i++) begin
            wdata_q.push_back($urandom);
            wstrb_q.push_back(full ? 4'hF : axi_pkg::strb_t'($urandom));
        end
    endtask

    task automatic single_beat(input axi_pkg::strb_t strb);
        wdata_q.delete();
        wstrb_q.delete();
        wdata_q.push_back($urandom);
        wstrb_q.push_back(strb);
    endtask

    // Spurious or wrong tx strobes
    always @(negedge clk) begin
        if (!reset && tx_valid) begin
            check_true("tx_valid pulsed with no byte pending", exp_bytes.size() != 0);
            if (exp_bytes.size() != 0)
                check_value("tx_byte", exp_bytes.pop_front(), tx_byte);
        end
    end

    // --------------------------------------------------
    // Manager port transactions
    // --------------------------------------------------
    task automatic do_write(input soc_pkg::target_e tgt, input axi_pkg::addr_t addr,
                            input axi_pkg::id_t id, input axi_pkg::len_t len);
        axi_pkg::b_t      held;
        logic             stalled;
        int               n;
        int               wi;
        @(posedge clk);
        s_aw      <= '{addr: addr, id: id, len: len, size: 3'd2, burst: axi_pkg::BURST_INCR};
        s_awvalid <= 1'b1;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (s_awready)
                break;
        end
        if (n == TIMEOUT)
            abort_on_timeout("awready");
        @(posedge clk);
        s_awvalid <= 1'b0;

        for (int beat = 0; beat <= int'(len); beat++) begin
            s_w      <= '{data: wdata_q[beat], strb: wstrb_q[beat], last: beat == int'(len)};
            s_wvalid <= 1'b1;
            for (n = 0; n < TIMEOUT; n++) begin
                @(negedge clk);
                if (s_wready)
                    break;
            end
            if (n == TIMEOUT)
                abort_on_timeout("wready");
            @(posedge clk);
            if (tgt == soc_pkg::TGT_SRAM) begin
                wi = word_of(addr, beat);
                for (int i = 0; i < `DATA_W / 8; i++) begin
                    if (wstrb_q[beat][i])
                        sb_mem[wi][8*i +: 8] = wdata_q[beat][8*i +: 8];
                end
            end else if (tgt == soc_pkg::TGT_UART && wstrb_q[beat][0]) begin
                exp_bytes.push_back(wdata_q[beat][7:0]);
                tx_count++;
            end
        end
        s_wvalid <= 1'b0;

        s_bready <= pick_ready();
        stalled = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (stalled) begin
                check_true("bvalid dropped while stalled", s_bvalid);
                check_value("b while stalled", 64'(held), 64'(s_b));
            end
            if (s_bvalid && s_bready)
                break;
            if (s_bvalid) begin
                check_true("awready high while B is pending", !s_awready);
                held    = s_b;
                stalled = 1'b1;
            end
            @(posedge clk);
            s_bready <= pick_ready();
        end
        if (n == TIMEOUT) begin
            abort_on_timeout("bvalid");
        end else begin
            check_value("bid", 64'(id), 64'(s_b.id));
            check_value("bresp", 64'(exp_resp(tgt)), 64'(s_b.resp));
        end
        @(posedge clk);
        s_bready <= 1'b0;
        if (tgt == soc_pkg::TGT_UART)
            check_value("tx bytes never sent", 0, 64'(exp_bytes.size()));
    endtask

    task automatic do_read(input soc_pkg::target_e tgt, input axi_pkg::addr_t addr,
                           input axi_pkg::id_t id, input axi_pkg::len_t len);
        axi_pkg::r_t      held;
        axi_pkg::data_t   exp_data;
        logic             stalled;
        logic             done;
        int               n;
        int               beat;
        @(posedge clk);
        s_ar      <= '{addr: addr, id: id, len: len, size: 3'd2, burst: axi_pkg::BURST_INCR};
        s_arvalid <= 1'b1;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (s_arready)
                break;
        end
        if (n == TIMEOUT)
            abort_on_timeout("arready");
        @(posedge clk);
        s_arvalid <= 1'b0;
        s_rready  <= pick_ready();

        stalled = 1'b0;
        done    = 1'b0;
        beat    = 0;
        for (n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            if (stalled) begin
                check_true("rvalid dropped while stalled", s_rvalid);
                check_value("r while stalled", 64'(held), 64'(s_r));
            end
            if (s_rvalid && s_rready) begin
                if (tgt == soc_pkg::TGT_SRAM)
                    exp_data = sb_mem[word_of(addr, beat)];
                else if (tgt == soc_pkg::TGT_UART)
                    exp_data = axi_pkg::data_t'(tx_count % 256);
                else
                    exp_data = '0;
                check_value($sformatf("rdata beat %0d", beat), 64'(exp_data), 64'(s_r.data));
                check_value("rid", 64'(id), 64'(s_r.id));
                check_value("rresp", 64'(exp_resp(tgt)), 64'(s_r.resp));
                check_value($sformatf("rlast beat %0d", beat), 64'(beat == int'(len)),
                            64'(s_r.last));
                done    = s_r.last;
                stalled = 1'b0;
                beat++;
            end else if (s_rvalid) begin
                check_true("arready high while R is pending", !s_arready);
                held    = s_r;
                stalled = 1'b1;
            end
            @(posedge clk);
            s_rready <= done ? 1'b0 : pick_ready();
        end
        if (!done)
            abort_on_timeout("the last R beat");
        else
            check_value("beat count", 64'(int'(len) + 1), 64'(beat));
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        axi_pkg::addr_t b_addr [6];
        axi_pkg::len_t  b_len [6];
        axi_pkg::id_t   b_id [6];
        axi_pkg::addr_t holes [4];
        axi_pkg::addr_t addr;
        axi_pkg::len_t  len;
        axi_pkg::strb_t strb;

        void'($urandom(83676));
        clk       = 1'b0;
        reset     = 1'b1;
        s_aw      = '0;
        s_awvalid = 1'b0;
        s_w       = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_ar      = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        stall_en  = 1'b0;
        tx_count  = 0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_state");
        @(negedge clk);
        check_value("bvalid after reset", 0, 64'(s_bvalid));
        check_value("rvalid after reset", 0, 64'(s_rvalid));
        check_value("tx_valid after reset", 0, 64'(tx_valid));
        do_read(soc_pkg::TGT_UART, `UART_BASE,
                axi_pkg::id_t'($urandom_range(0, 15)), 8'd0);
        finish_test();

        // Each burst is filled whole, then rewritten under random strobes
        start_test("sram_burst");
        for (int i = 0; i < 6; i++) begin
            b_addr[i] = `SRAM_BASE | ($urandom & 32'h0FFF_FFFC);
            b_len[i]  = axi_pkg::len_t'($urandom_range(0, 15));
            b_id[i]   = axi_pkg::id_t'($urandom_range(0, 15));
            fill_beats(b_len[i], 1'b1);
            do_write(soc_pkg::TGT_SRAM, b_addr[i], b_id[i], b_len[i]);
            fill_beats(b_len[i], 1'b0);
            do_write(soc_pkg::TGT_SRAM, b_addr[i], b_id[i], b_len[i]);
        end
        for (int i = 0; i < 6; i++)
            do_read(soc_pkg::TGT_SRAM, b_addr[i], b_id[i], b_len[i]);
        finish_test();

        start_test("uart_tx");
        for (int i = 0; i < 8; i++) begin
            strb    = axi_pkg::strb_t'($urandom);
            strb[0] = i % 3 != 2;   // Every third write has lane 0 off
            single_beat(strb);
            do_write(soc_pkg::TGT_UART, `UART_BASE,
                     axi_pkg::id_t'($urandom_range(0, 15)), 8'd0);
        end
        do_read(soc_pkg::TGT_UART, `UART_BASE,
                axi_pkg::id_t'($urandom_range(0, 15)), 8'd0);
        finish_test();

        start_test("unmapped");
        holes[0] = 32'h2000_0000;
        holes[1] = `UART_BASE + 32'd4;
        holes[2] = `SRAM_LAST + 32'd1;
        holes[3] = 32'h0000_0000;
        for (int i = 0; i < 4; i++) begin
            len = axi_pkg::len_t'($urandom_range(0, 7));
            fill_beats(len, 1'b0);
            do_write(soc_pkg::TGT_NONE, holes[i],
                     axi_pkg::id_t'($urandom_range(0, 15)), len);
            do_read(soc_pkg::TGT_NONE, holes[i], axi_pkg::id_t'($urandom_range(0, 15)),
                    axi_pkg::len_t'($urandom_range(0, 7)));
        end
        finish_test();

        // Targets alternate under random bready and rready stalls
        start_test("backpressure");
        stall_en = 1'b1;
        for (int i = 0; i < 3; i++) begin
            addr = `SRAM_BASE | ($urandom & 32'h0FFF_FFFC);
            len  = axi_pkg::len_t'($urandom_range(1, 15));
            fill_beats(len, 1'b1);
            do_write(soc_pkg::TGT_SRAM, addr,
                     axi_pkg::id_t'($urandom_range(0, 15)), len);
            single_beat(axi_pkg::strb_t'($urandom));
            do_write(soc_pkg::TGT_UART, `UART_BASE,
                     axi_pkg::id_t'($urandom_range(0, 15)), 8'd0);
            fill_beats(8'd2, 1'b1);
            do_write(soc_pkg::TGT_NONE, holes[i],
                     axi_pkg::id_t'($urandom_range(0, 15)), 8'd2);
            do_read(soc_pkg::TGT_SRAM, addr,
                    axi_pkg::id_t'($urandom_range(0, 15)), len);
            do_read(soc_pkg::TGT_UART, `UART_BASE,
                    axi_pkg::id_t'($urandom_range(0, 15)), 8'd0);
            do_read(soc_pkg::TGT_NONE, holes[i],
                    axi_pkg::id_t'($urandom_range(0, 15)), 8'd3);
        end
        stall_en = 1'b0;
        finish_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
